// File: design/wb_pkg.sv
package wb_pkg;

  localparam int WB_AW = 16;
  localparam int WB_DW = 16;

  // slave address ranges
  localparam logic [15:0] SYSCONF_BASE = 16'h0000;
  localparam logic [15:0] SYSCONF_HIGH = 16'h000F;
  localparam logic [15:0] FROM_BASE    = 16'h0100;
  localparam logic [15:0] FROM_HIGH    = 16'h010F;
  localparam int NUM_SLAVES = 2;

  // word offsets inside the sysconf range
  localparam logic [3:0] REG_BOARD_ID  = 4'd0;
  localparam logic [3:0] REG_REV       = 4'd1;
  localparam logic [3:0] REG_CONFIG    = 4'd2;
  localparam logic [3:0] REG_SCRATCH   = 4'd3;
  localparam logic [3:0] REG_ERR_COUNT = 4'd4;
  localparam logic [3:0] REG_ERR_ADDR  = 4'd5;

  // board identity
  localparam logic [15:0] BOARD_ID       = 16'hB0A7;
  localparam logic [15:0] REVISION       = 16'h0103;
  localparam logic [7:0]  DEFAULT_CONFIG = 8'h00;

  // flashrom contents
  localparam logic [15:0] FROM_TABLE [16] = '{
    16'h5A00, 16'h5A01, 16'h5A02, 16'h5A03,
    16'h5A04, 16'h5A05, 16'h5A06, 16'h5A07,
    16'h5A08, 16'h5A09, 16'h5A0A, 16'h5A0B,
    16'h5A0C, 16'h5A0D, 16'h5A0E, 16'h5A0F
  };

endpackage

// File: design/serial_pkg.sv
package serial_pkg;

  // bit timing
  localparam int CLKS_PER_BIT = 16;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

  // host command and response bytes
  localparam logic [7:0] CMD_READ  = 8'h52;
  localparam logic [7:0] CMD_WRITE = 8'h57;
  localparam logic [7:0] RSP_OK    = 8'h4B;
  localparam logic [7:0] RSP_ERR   = 8'h45;
  localparam logic [7:0] RSP_BAD   = 8'h3F;

  // command parser states
  localparam logic [2:0] BR_OP   = 3'd0;
  localparam logic [2:0] BR_A_HI = 3'd1;
  localparam logic [2:0] BR_A_LO = 3'd2;
  localparam logic [2:0] BR_D_HI = 3'd3;
  localparam logic [2:0] BR_D_LO = 3'd4;
  localparam logic [2:0] BR_BUS  = 3'd5;
  localparam logic [2:0] BR_RSP  = 3'd6;

endpackage

// File: design/serial_uart.sv
`timescale 1ns/1ns

module serial_uart (
  input  logic       gclk40,
  input  logic       hard_reset,
  input  logic       serial_in_i,
  output logic       serial_out_o,
  output logic [7:0] rx_data_o,
  output logic       rx_dstrb_o,
  input  logic [7:0] tx_data_i,
  input  logic       tx_dstrb_i,
  output logic       tx_busy_o
);

  logic [1:0] rx_sync;
  logic       rx_s;
  logic       rx_active;
  logic [serial_pkg::CNT_W-1:0] rx_cnt;
  logic [3:0] rx_idx;
  logic [7:0] rx_shift;

  logic [9:0] tx_shift;
  logic [serial_pkg::CNT_W-1:0] tx_cnt;
  logic [3:0] tx_idx;

  assign rx_s         = rx_sync[1];
  assign rx_data_o    = rx_shift;
  assign serial_out_o = tx_shift[0];

  // receiver, rx_idx 0 is the start bit and 9 the stop bit
  always_ff @(posedge gclk40) begin
    rx_sync    <= {rx_sync[0], serial_in_i};
    rx_dstrb_o <= 1'b0;
    if (hard_reset) begin
      rx_sync   <= 2'b11;
      rx_active <= 1'b0;
      rx_cnt    <= '0;
      rx_idx    <= 4'd0;
    end else if (!rx_active) begin
      if (!rx_s) begin
        rx_active <= 1'b1;
        rx_cnt    <= '0;
        rx_idx    <= 4'd0;
      end
    end else if (rx_idx == 4'd0) begin
      // check the start bit in its middle, drop glitches
      if (rx_cnt == serial_pkg::BIT_HALF) begin
        rx_cnt <= '0;
        if (rx_s) begin
          rx_active <= 1'b0;
        end else begin
          rx_idx <= 4'd1;
        end
      end else begin
        rx_cnt <= rx_cnt + 1'b1;
      end
    end else if (rx_cnt == serial_pkg::BIT_LAST) begin
      rx_cnt <= '0;
      if (rx_idx == 4'd9) begin
        rx_active  <= 1'b0;
        rx_dstrb_o <= rx_s;
      end else begin
        rx_shift <= {rx_s, rx_shift[7:1]};
        rx_idx   <= rx_idx + 4'd1;
      end
    end else begin
      rx_cnt <= rx_cnt + 1'b1;
    end
  end

  // transmitter, shifts in ones so the line rests high
  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      tx_shift  <= '1;
      tx_busy_o <= 1'b0;
      tx_cnt    <= '0;
      tx_idx    <= 4'd0;
    end else if (!tx_busy_o) begin
      if (tx_dstrb_i) begin
        tx_shift  <= {1'b1, tx_data_i, 1'b0};
        tx_busy_o <= 1'b1;
        tx_cnt    <= '0;
        tx_idx    <= 4'd0;
      end
    end else if (tx_cnt == serial_pkg::BIT_LAST) begin
      tx_cnt <= '0;
      if (tx_idx == 4'd9) begin
        // end of stop bit
        tx_busy_o <= 1'b0;
      end else begin
        tx_shift <= {1'b1, tx_shift[9:1]};
        tx_idx   <= tx_idx + 4'd1;
      end
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

endmodule

// File: design/as_wb_bridge.sv
`timescale 1ns/1ns

module as_wb_bridge (
  input  logic                     gclk40,
  input  logic                     hard_reset,
  input  logic [7:0]               rx_data_i,
  input  logic                     rx_dstrb_i,
  output logic [7:0]               tx_data_o,
  output logic                     tx_dstrb_o,
  input  logic                     tx_busy_i,
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic                     wb_we_o,
  output logic [wb_pkg::WB_AW-1:0] wb_adr_o,
  output logic [wb_pkg::WB_DW-1:0] wb_dat_o,
  input  logic [wb_pkg::WB_DW-1:0] wb_dat_i,
  input  logic                     wb_ack_i,
  input  logic                     wb_err_i
);

  logic [2:0]  state;
  logic [23:0] rsp_buf;
  logic [1:0]  rsp_cnt;

  always_ff @(posedge gclk40) begin
    tx_dstrb_o <= 1'b0;
    if (hard_reset) begin
      state    <= serial_pkg::BR_OP;
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
      rsp_cnt  <= 2'd0;
    end else begin
      case (state)
        serial_pkg::BR_OP: begin
          if (rx_dstrb_i) begin
            if (rx_data_i == serial_pkg::CMD_READ || rx_data_i == serial_pkg::CMD_WRITE) begin
              wb_we_o <= (rx_data_i == serial_pkg::CMD_WRITE);
              state   <= serial_pkg::BR_A_HI;
            end else begin
              // unknown opcode, answer without a bus cycle
              rsp_buf <= {serial_pkg::RSP_BAD, 16'h0000};
              rsp_cnt <= 2'd1;
              state   <= serial_pkg::BR_RSP;
            end
          end
        end
        serial_pkg::BR_A_HI: begin
          if (rx_dstrb_i) begin
            wb_adr_o[15:8] <= rx_data_i;
            state          <= serial_pkg::BR_A_LO;
          end
        end
        serial_pkg::BR_A_LO: begin
          if (rx_dstrb_i) begin
            wb_adr_o[7:0] <= rx_data_i;
            if (wb_we_o) begin
              state <= serial_pkg::BR_D_HI;
            end else begin
              wb_cyc_o <= 1'b1;
              wb_stb_o <= 1'b1;
              state    <= serial_pkg::BR_BUS;
            end
          end
        end
        serial_pkg::BR_D_HI: begin
          if (rx_dstrb_i) begin
            wb_dat_o[15:8] <= rx_data_i;
            state          <= serial_pkg::BR_D_LO;
          end
        end
        serial_pkg::BR_D_LO: begin
          if (rx_dstrb_i) begin
            wb_dat_o[7:0] <= rx_data_i;
            wb_cyc_o      <= 1'b1;
            wb_stb_o      <= 1'b1;
            state         <= serial_pkg::BR_BUS;
          end
        end
        serial_pkg::BR_BUS: begin
          if (wb_ack_i || wb_err_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            state    <= serial_pkg::BR_RSP;
            if (wb_err_i) begin
              rsp_buf <= {serial_pkg::RSP_ERR, 16'h0000};
              rsp_cnt <= 2'd1;
            end else if (wb_we_o) begin
              rsp_buf <= {serial_pkg::RSP_OK, 16'h0000};
              rsp_cnt <= 2'd1;
            end else begin
              rsp_buf <= {serial_pkg::RSP_OK, wb_dat_i};
              rsp_cnt <= 2'd3;
            end
          end
        end
        default: begin
          // one byte per free transmitter, back to idle once the last is out
          if (!tx_busy_i && !tx_dstrb_o) begin
            if (rsp_cnt == 2'd0) begin
              state <= serial_pkg::BR_OP;
            end else begin
              tx_dstrb_o <= 1'b1;
              tx_data_o  <= rsp_buf[23:16];
              rsp_buf    <= {rsp_buf[15:0], 8'h00};
              rsp_cnt    <= rsp_cnt - 2'd1;
            end
          end
        end
      endcase
    end
  end

endmodule

// File: design/wbs_arbiter.sv
`timescale 1ns/1ns

module wbs_arbiter (
  input  logic                                         gclk40,
  input  logic                                         hard_reset,
  input  logic                                         wbm_cyc_i,
  input  logic                                         wbm_stb_i,
  input  logic                                         wbm_we_i,
  input  logic [wb_pkg::WB_AW-1:0]                     wbm_adr_i,
  input  logic [wb_pkg::WB_DW-1:0]                     wbm_dat_i,
  output logic [wb_pkg::WB_DW-1:0]                     wbm_dat_o,
  output logic                                         wbm_ack_o,
  output logic                                         wbm_err_o,
  output logic [wb_pkg::NUM_SLAVES-1:0]                wbs_cyc_o,
  output logic [wb_pkg::NUM_SLAVES-1:0]                wbs_stb_o,
  output logic                                         wbs_we_o,
  output logic [wb_pkg::WB_AW-1:0]                     wbs_adr_o,
  output logic [wb_pkg::WB_DW-1:0]                     wbs_dat_o,
  input  logic [wb_pkg::NUM_SLAVES*wb_pkg::WB_DW-1:0]  wbs_dat_i,
  input  logic [wb_pkg::NUM_SLAVES-1:0]                wbs_ack_i,
  output logic                                         bm_err_o,
  output logic [wb_pkg::WB_AW-1:0]                     bm_addr_o
);

  logic                         hit_sys;
  logic                         hit_from;
  logic                         bad;
  logic [wb_pkg::NUM_SLAVES-1:0] sel;

  // address decode
  assign hit_sys  = (wbm_adr_i >= wb_pkg::SYSCONF_BASE) && (wbm_adr_i <= wb_pkg::SYSCONF_HIGH);
  assign hit_from = (wbm_adr_i >= wb_pkg::FROM_BASE) && (wbm_adr_i <= wb_pkg::FROM_HIGH);

  // rom range is read only
  assign sel = {hit_from && !wbm_we_i, hit_sys};
  assign bad = ~|sel;

  assign wbs_cyc_o = {wb_pkg::NUM_SLAVES{wbm_cyc_i}} & sel;
  assign wbs_stb_o = {wb_pkg::NUM_SLAVES{wbm_stb_i}} & sel;
  assign wbs_we_o  = wbm_we_i;
  assign wbs_adr_o = wbm_adr_i;
  assign wbs_dat_o = wbm_dat_i;

  assign wbm_dat_o = sel[1] ? wbs_dat_i[2*wb_pkg::WB_DW-1:wb_pkg::WB_DW]
                            : wbs_dat_i[wb_pkg::WB_DW-1:0];
  assign wbm_ack_o = |(wbs_ack_i & sel);
  assign bm_err_o  = wbm_err_o;

  // err one clock after stb, single cycle
  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      wbm_err_o <= 1'b0;
    end else begin
      wbm_err_o <= wbm_cyc_i && wbm_stb_i && bad && !wbm_err_o;
    end
  end

  // offending address for the bus monitor
  always_ff @(posedge gclk40) begin
    if (wbm_cyc_i && wbm_stb_i && bad) begin
      bm_addr_o <= wbm_adr_i;
    end
  end

endmodule

// File: design/sys_config.sv
`timescale 1ns/1ns

module sys_config (
  input  logic                     gclk40,
  input  logic                     hard_reset,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [wb_pkg::WB_AW-1:0] wb_adr_i,
  input  logic [wb_pkg::WB_DW-1:0] wb_dat_i,
  output logic [wb_pkg::WB_DW-1:0] wb_dat_o,
  output logic                     wb_ack_o,
  input  logic                     bm_err_i,
  input  logic [wb_pkg::WB_AW-1:0] bm_addr_i,
  output logic [7:0]               sys_config_o
);

  logic        access;
  logic [15:0] scratch;
  logic [15:0] err_count;
  logic [15:0] err_addr;

  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      wb_ack_o     <= 1'b0;
      sys_config_o <= wb_pkg::DEFAULT_CONFIG;
      err_count    <= 16'h0000;
      err_addr     <= 16'h0000;
    end else begin
      wb_ack_o <= access;
      // board id and revision ignore writes
      if (access && wb_we_i && wb_adr_i[3:0] == wb_pkg::REG_CONFIG) begin
        sys_config_o <= wb_dat_i[7:0];
      end
      if (bm_err_i) begin
        err_addr <= bm_addr_i;
        if (err_count != 16'hFFFF) begin
          err_count <= err_count + 16'h0001;
        end
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access && wb_we_i && wb_adr_i[3:0] == wb_pkg::REG_SCRATCH) begin
      scratch <= wb_dat_i;
    end
    if (access) begin
      case (wb_adr_i[3:0])
        wb_pkg::REG_BOARD_ID:  wb_dat_o <= wb_pkg::BOARD_ID;
        wb_pkg::REG_REV:       wb_dat_o <= wb_pkg::REVISION;
        wb_pkg::REG_CONFIG:    wb_dat_o <= {8'h00, sys_config_o};
        wb_pkg::REG_SCRATCH:   wb_dat_o <= scratch;
        wb_pkg::REG_ERR_COUNT: wb_dat_o <= err_count;
        wb_pkg::REG_ERR_ADDR:  wb_dat_o <= err_addr;
        default:               wb_dat_o <= 16'h0000;
      endcase
    end
  end

endmodule

// File: design/from_controller.sv
`timescale 1ns/1ns

module from_controller (
  input  logic                     gclk40,
  input  logic                     hard_reset,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic [wb_pkg::WB_AW-1:0] wb_adr_i,
  output logic [wb_pkg::WB_DW-1:0] wb_dat_o,
  output logic                     wb_ack_o
);

  // address stage of the flash array
  logic       addr_vld;
  logic [3:0] addr_q;

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      addr_vld <= 1'b0;
      wb_ack_o <= 1'b0;
    end else begin
      addr_vld <= wb_cyc_i && wb_stb_i && !addr_vld && !wb_ack_o;
      wb_ack_o <= addr_vld;
    end
  end

  always_ff @(posedge gclk40) begin
    if (wb_cyc_i && wb_stb_i && !addr_vld) begin
      addr_q <= wb_adr_i[3:0];
    end
    // data stage
    if (addr_vld) begin
      wb_dat_o <= wb_pkg::FROM_TABLE[addr_q];
    end
  end

endmodule

// File: design/board_ctrl_top.sv
`timescale 1ns/1ns

module board_ctrl_top (
  input  logic       gclk40,
  input  logic       hard_reset,
  input  logic       serial_in_i,
  output logic       serial_out_o,
  output logic [7:0] sys_config_o,
  output logic       debug_led_o
);

  // uart to bridge bytes
  logic [7:0] rx_data;
  logic       rx_dstrb;
  logic [7:0] tx_data;
  logic       tx_dstrb;
  logic       tx_busy;

  // master side wishbone
  logic                     wbm_cyc;
  logic                     wbm_stb;
  logic                     wbm_we;
  logic [wb_pkg::WB_AW-1:0] wbm_adr;
  logic [wb_pkg::WB_DW-1:0] wbm_dat_w;
  logic [wb_pkg::WB_DW-1:0] wbm_dat_r;
  logic                     wbm_ack;
  logic                     wbm_err;

  // slave side wishbone
  logic [wb_pkg::NUM_SLAVES-1:0]               wbs_cyc;
  logic [wb_pkg::NUM_SLAVES-1:0]               wbs_stb;
  logic                                        wbs_we;
  logic [wb_pkg::WB_AW-1:0]                    wbs_adr;
  logic [wb_pkg::WB_DW-1:0]                    wbs_dat_w;
  logic [wb_pkg::NUM_SLAVES*wb_pkg::WB_DW-1:0] wbs_dat_r;
  logic [wb_pkg::NUM_SLAVES-1:0]               wbs_ack;

  logic                     bm_err;
  logic [wb_pkg::WB_AW-1:0] bm_addr;
  logic                     cyc_d;

  serial_uart u_uart (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .serial_in_i(serial_in_i), .serial_out_o(serial_out_o),
    .rx_data_o(rx_data), .rx_dstrb_o(rx_dstrb),
    .tx_data_i(tx_data), .tx_dstrb_i(tx_dstrb), .tx_busy_o(tx_busy)
  );

  as_wb_bridge u_bridge (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .rx_data_i(rx_data), .rx_dstrb_i(rx_dstrb),
    .tx_data_o(tx_data), .tx_dstrb_o(tx_dstrb), .tx_busy_i(tx_busy),
    .wb_cyc_o(wbm_cyc), .wb_stb_o(wbm_stb), .wb_we_o(wbm_we),
    .wb_adr_o(wbm_adr), .wb_dat_o(wbm_dat_w), .wb_dat_i(wbm_dat_r),
    .wb_ack_i(wbm_ack), .wb_err_i(wbm_err)
  );

  wbs_arbiter u_arbiter (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .wbm_cyc_i(wbm_cyc), .wbm_stb_i(wbm_stb), .wbm_we_i(wbm_we),
    .wbm_adr_i(wbm_adr), .wbm_dat_i(wbm_dat_w), .wbm_dat_o(wbm_dat_r),
    .wbm_ack_o(wbm_ack), .wbm_err_o(wbm_err),
    .wbs_cyc_o(wbs_cyc), .wbs_stb_o(wbs_stb), .wbs_we_o(wbs_we),
    .wbs_adr_o(wbs_adr), .wbs_dat_o(wbs_dat_w), .wbs_dat_i(wbs_dat_r),
    .wbs_ack_i(wbs_ack),
    .bm_err_o(bm_err), .bm_addr_o(bm_addr)
  );

  sys_config u_sys_config (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .wb_cyc_i(wbs_cyc[0]), .wb_stb_i(wbs_stb[0]), .wb_we_i(wbs_we),
    .wb_adr_i(wbs_adr), .wb_dat_i(wbs_dat_w), .wb_dat_o(wbs_dat_r[15:0]),
    .wb_ack_o(wbs_ack[0]),
    .bm_err_i(bm_err), .bm_addr_i(bm_addr),
    .sys_config_o(sys_config_o)
  );

  from_controller u_from (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .wb_cyc_i(wbs_cyc[1]), .wb_stb_i(wbs_stb[1]),
    .wb_adr_i(wbs_adr), .wb_dat_o(wbs_dat_r[31:16]),
    .wb_ack_o(wbs_ack[1])
  );

  // led flips on each new bridge cycle
  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      cyc_d       <= 1'b0;
      debug_led_o <= 1'b0;
    end else begin
      cyc_d <= wbm_cyc;
      if (wbm_cyc && !cyc_d) begin
        debug_led_o <= ~debug_led_o;
      end
    end
  end

endmodule

// File: bench/tb_serial_host.svh
// host side of the serial link, 8N1, lsb first

task automatic send_byte(input logic [7:0] b);
  logic [9:0] frame;
  int i;
  begin
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge gclk40);
      #1 serial_in = frame[i];
      repeat (serial_pkg::CLKS_PER_BIT - 1) @(posedge gclk40);
    end
  end
endtask

// sample each bit near its middle on the falling clock edge
task automatic recv_byte(output logic [7:0] b);
  int i;
  begin
    @(negedge serial_out);
    repeat (serial_pkg::CLKS_PER_BIT / 2) @(negedge gclk40);
    assert (serial_out === 1'b0) else begin
      abort_run("start bit on serial_out_o did not stay low");
    end
    for (i = 0; i < 8; i++) begin
      repeat (serial_pkg::CLKS_PER_BIT) @(negedge gclk40);
      b[i] = serial_out;
    end
    repeat (serial_pkg::CLKS_PER_BIT) @(negedge gclk40);
    assert (serial_out === 1'b1) else begin
      abort_run("stop bit on serial_out_o is missing");
    end
  end
endtask

// File: bench/tb_board_ctrl.sv
`timescale 1ns/1ns

module tb_board_ctrl;

  localparam int CLK_NS = 8;
  localparam int FRAME_NS = 10 * serial_pkg::CLKS_PER_BIT * CLK_NS;
  // forty transactions of six frames each plus margin
  localparam int WATCHDOG_NS = 40 * 6 * FRAME_NS + 20000;
  localparam logic [15:0] UNMAPPED_ADDR = 16'h0800;

  logic       gclk40;
  logic       hard_reset;
  logic       serial_in;
  logic       serial_out;
  logic [7:0] sys_config;
  logic       debug_led;

  // commands that reached the bus
  int          bus_cmds;
  logic [15:0] rnd_val;
  logic [3:0]  rom_idx;
  logic [7:0]  rsp;
  logic [15:0] rdata;

  board_ctrl_top DUT (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .serial_in_i(serial_in), .serial_out_o(serial_out),
    .sys_config_o(sys_config), .debug_led_o(debug_led)
  );

  always #(CLK_NS / 2) gclk40 = ~gclk40;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

`include "tb_serial_host.svh"

  function automatic logic [15:0] sys_addr(input logic [3:0] off);
    sys_addr = wb_pkg::SYSCONF_BASE + {12'h000, off};
  endfunction

  function automatic logic [15:0] rom_addr(input logic [3:0] idx);
    rom_addr = wb_pkg::FROM_BASE + {12'h000, idx};
  endfunction

  // led toggles once per bus cycle
  task automatic check_led();
    check_value("led_parity", {15'h0000, bus_cmds[0]}, {15'h0000, debug_led});
  endtask

  // receiver runs in parallel since the reply can start inside the last stop bit
  task automatic write_word(input logic [15:0] addr, input logic [15:0] data,
                            output logic [7:0] rsp_o);
    fork
      begin
        send_byte(serial_pkg::CMD_WRITE);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
        send_byte(data[15:8]);
        send_byte(data[7:0]);
      end
      recv_byte(rsp_o);
    join
    bus_cmds++;
  endtask

  task automatic read_word(input logic [15:0] addr, output logic [7:0] rsp_o,
                           output logic [15:0] data_o);
    logic [7:0] hi;
    logic [7:0] lo;
    data_o = 16'hxxxx;
    fork
      begin
        send_byte(serial_pkg::CMD_READ);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
      end
      begin
        recv_byte(rsp_o);
        if (rsp_o == serial_pkg::RSP_OK) begin
          recv_byte(hi);
          recv_byte(lo);
          data_o = {hi, lo};
        end
      end
    join
    bus_cmds++;
  endtask

  task automatic expect_write(input string name, input logic [15:0] addr,
                              input logic [15:0] data, input logic [7:0] exp_rsp);
    logic [7:0] r;
    write_word(addr, data, r);
    check_value({name, "_rsp"}, {8'h00, exp_rsp}, {8'h00, r});
    check_led();
  endtask

  task automatic expect_read(input string name, input logic [15:0] addr,
                             input logic [15:0] exp);
    logic [7:0]  r;
    logic [15:0] d;
    read_word(addr, r, d);
    check_value({name, "_rsp"}, {8'h00, serial_pkg::RSP_OK}, {8'h00, r});
    check_value(name, exp, d);
    check_led();
  endtask

  // single opcode byte that never reaches the bus
  task automatic send_raw_cmd(input logic [7:0] op, output logic [7:0] rsp_o);
    fork
      send_byte(op);
      recv_byte(rsp_o);
    join
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the test sequence finished");
  end

  initial begin
    int n;
    gclk40     = 1'b0;
    hard_reset = 1'b1;
    serial_in  = 1'b1;
    bus_cmds   = 0;
    void'($urandom(32'h4e9e));
    repeat (10) @(posedge gclk40);
    #1 hard_reset = 1'b0;

    // reset values and identity
    check_value("reset_serial_out", 16'h0001, {15'h0000, serial_out});
    check_value("reset_led", 16'h0000, {15'h0000, debug_led});
    check_value("reset_config", {8'h00, wb_pkg::DEFAULT_CONFIG}, {8'h00, sys_config});
    expect_read("board_id", sys_addr(wb_pkg::REG_BOARD_ID), wb_pkg::BOARD_ID);
    expect_read("revision", sys_addr(wb_pkg::REG_REV), wb_pkg::REVISION);

    // writable registers
    rnd_val = $urandom;
    expect_write("scratch_write", sys_addr(wb_pkg::REG_SCRATCH), rnd_val, serial_pkg::RSP_OK);
    expect_read("scratch_read", sys_addr(wb_pkg::REG_SCRATCH), rnd_val);
    expect_write("config_write", sys_addr(wb_pkg::REG_CONFIG), 16'h3CA5, serial_pkg::RSP_OK);
    check_value("config_pins", 16'h00A5, {8'h00, sys_config});
    expect_read("config_read", sys_addr(wb_pkg::REG_CONFIG), 16'h00A5);
    expect_write("id_write", sys_addr(wb_pkg::REG_BOARD_ID), 16'h1234, serial_pkg::RSP_OK);
    expect_read("id_unchanged", sys_addr(wb_pkg::REG_BOARD_ID), wb_pkg::BOARD_ID);

    // rom table at random indices, entry n holds 5A00 plus n
    for (n = 0; n < 4; n++) begin
      rom_idx = $urandom % 16;
      expect_read("rom_read", rom_addr(rom_idx), 16'h5A00 + {12'h000, rom_idx});
    end

    // bus errors and their statistics
    rnd_val = $urandom;
    expect_write("rom_write", rom_addr(4'd3), rnd_val, serial_pkg::RSP_ERR);
    read_word(UNMAPPED_ADDR, rsp, rdata);
    check_value("unmapped_read", {8'h00, serial_pkg::RSP_ERR}, {8'h00, rsp});
    check_led();
    expect_read("err_count", sys_addr(wb_pkg::REG_ERR_COUNT), 16'd2);
    expect_read("err_addr", sys_addr(wb_pkg::REG_ERR_ADDR), UNMAPPED_ADDR);

    // unknown opcode followed by a normal read
    send_raw_cmd(8'h58, rsp);
    check_value("unknown_op", {8'h00, serial_pkg::RSP_BAD}, {8'h00, rsp});
    check_led();
    expect_read("id_after_bad", sys_addr(wb_pkg::REG_BOARD_ID), wb_pkg::BOARD_ID);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: src.f
+incdir+bench
design/wb_pkg.sv
design/serial_pkg.sv
design/serial_uart.sv
design/as_wb_bridge.sv
design/wbs_arbiter.sv
design/sys_config.sv
design/from_controller.sv
design/board_ctrl_top.sv
bench/tb_board_ctrl.sv

// File: Bender.yml
package:
  name: board_ctrl

sources:
  - files:
      - design/wb_pkg.sv
      - design/serial_pkg.sv
      - design/serial_uart.sv
      - design/as_wb_bridge.sv
      - design/wbs_arbiter.sv
      - design/sys_config.sv
      - design/from_controller.sv
      - design/board_ctrl_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_board_ctrl.sv
